//--- all.f
logic/coreCtrlPkg.sv
logic/pipeIfs.sv
logic/pipeCtrl.sv
logic/instDecoder.sv
logic/immGen.sv
logic/ctrlPipe.sv
logic/coreCtrlTop.sv
sim/coreCtrlTb.sv

//--- logic/coreCtrlPkg.sv
// Shared widths, opcodes and decode encodings for the RV32I control path
// Used by every block of the Q101 to Q105 pipe control
package coreCtrlPkg;

    //--------------------------------------------------
    // Plain vectors with a meaning
    //--------------------------------------------------
    typedef logic [31:0] tWord;    // Instruction or data word
    typedef logic [4:0]  tRegIdx;  // x0..x31
    typedef logic [3:0]  tByteEn;  // One bit per byte lane

    //--------------------------------------------------
    // Decode encodings
    //--------------------------------------------------
    // Major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        I_OP   = 7'b0010011,
        R_OP   = 7'b0110011,
        FENCE  = 7'b0001111,
        SYSCAL = 7'b1110011
    } tOpcode;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } tAluOp;

    // Straight from funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } tBranchType;

    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_DMEM = 2'b01,
        WB_PC4  = 2'b10  // Link address for JAL/JALR
    } tSelWrBack;

    typedef enum logic [2:0] {
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } tImmType;

    //--------------------------------------------------
    // Constants
    //--------------------------------------------------
    localparam tWord   NOP_INST  = 32'h0000_0013;  // ADDI x0, x0, 0
    localparam tByteEn BYTE_EN_B = 4'b0001;
    localparam tByteEn BYTE_EN_H = 4'b0011;
    localparam tByteEn BYTE_EN_W = 4'b1111;

endpackage

//--- logic/coreCtrlTop.sv
// Control path top for the five-stage RV32I pipe
// Hazard control, decode, immediate and stage registers
module coreCtrlTop (
    input  logic                    Clock,
    input  logic                    reset,
    input  coreCtrlPkg::tWord       PreInstructionQ101H,
    input  logic                    BranchCondMetQ102H,
    input  logic                    DMemReady,
    // Back-pressure
    output logic                    ReadyQ100H,
    output logic                    ReadyQ101H,
    output logic                    ReadyQ102H,  // Shared by Q102..Q105
    // Decode
    output coreCtrlPkg::tWord       ImmediateQ101H,
    output coreCtrlPkg::tRegIdx     RegSrc1Q101H,
    output coreCtrlPkg::tRegIdx     RegSrc2Q101H,
    output logic                    SelNextPcAluOutQ102H,
    // Execute
    output coreCtrlPkg::tAluOp      AluOpQ102H,
    output logic                    SelAluPcQ102H,
    output logic                    SelAluImmQ102H,
    output logic                    LuiQ102H,
    output coreCtrlPkg::tBranchType BranchOpQ102H,
    // Memory
    output logic                    DMemWrEnQ103H,
    output logic                    DMemRdEnQ103H,
    output coreCtrlPkg::tByteEn     DMemByteEnQ103H,
    // Write-back
    output logic                    RegWrEnQ105H,
    output coreCtrlPkg::tRegIdx     RegDstQ105H,
    output logic                    SignExtQ105H,
    output coreCtrlPkg::tSelWrBack  SelWrBackQ105H,
    output coreCtrlPkg::tByteEn     ByteEnQ105H,
    output logic                    ValidInstQ105H
);
    import coreCtrlPkg::*;

    tWord InstructionQ101H;  // After NOP insertion

    decodeIf decBus ();
    hazardIf hzdBus ();

    assign ReadyQ102H = hzdBus.StageEn;

    pipeCtrl pipeCtrl_inst (
        .Clock                (Clock),
        .reset                (reset),
        .DMemReady            (DMemReady),
        .BranchCondMetQ102H   (BranchCondMetQ102H),
        .PreInstructionQ101H  (PreInstructionQ101H),
        .hazard               (hzdBus.ctrl),
        .InstructionQ101H     (InstructionQ101H),
        .ReadyQ100H           (ReadyQ100H),
        .ReadyQ101H           (ReadyQ101H),
        .SelNextPcAluOutQ102H (SelNextPcAluOutQ102H)
    );

    instDecoder instDecoder_inst (
        .InstructionQ101H (InstructionQ101H),
        .dec              (decBus.decoder),
        .RegSrc1Q101H     (RegSrc1Q101H),
        .RegSrc2Q101H     (RegSrc2Q101H)
    );

    immGen immGen_inst (
        .InstructionQ101H (InstructionQ101H),
        .ImmediateQ101H   (ImmediateQ101H)
    );

    ctrlPipe ctrlPipe_inst (
        .Clock           (Clock),
        .reset           (reset),
        .dec             (decBus.pipe),
        .hazard          (hzdBus.pipe),
        .AluOpQ102H      (AluOpQ102H),
        .SelAluPcQ102H   (SelAluPcQ102H),
        .SelAluImmQ102H  (SelAluImmQ102H),
        .LuiQ102H        (LuiQ102H),
        .BranchOpQ102H   (BranchOpQ102H),
        .DMemWrEnQ103H   (DMemWrEnQ103H),
        .DMemRdEnQ103H   (DMemRdEnQ103H),
        .DMemByteEnQ103H (DMemByteEnQ103H),
        .RegWrEnQ105H    (RegWrEnQ105H),
        .RegDstQ105H     (RegDstQ105H),
        .SignExtQ105H    (SignExtQ105H),
        .SelWrBackQ105H  (SelWrBackQ105H),
        .ByteEnQ105H     (ByteEnQ105H),
        .ValidInstQ105H  (ValidInstQ105H)
    );

endmodule

//--- logic/ctrlPipe.sv
// Control and valid registers for Q102 to Q105
// Drives per-stage execute, memory and write-back controls and the hazard status
module ctrlPipe (
    input  logic                    Clock,
    input  logic                    reset,
    decodeIf.pipe                   dec,
    hazardIf.pipe                   hazard,
    output coreCtrlPkg::tAluOp      AluOpQ102H,
    output logic                    SelAluPcQ102H,
    output logic                    SelAluImmQ102H,
    output logic                    LuiQ102H,
    output coreCtrlPkg::tBranchType BranchOpQ102H,
    output logic                    DMemWrEnQ103H,
    output logic                    DMemRdEnQ103H,
    output coreCtrlPkg::tByteEn     DMemByteEnQ103H,
    output logic                    RegWrEnQ105H,
    output coreCtrlPkg::tRegIdx     RegDstQ105H,
    output logic                    SignExtQ105H,
    output coreCtrlPkg::tSelWrBack  SelWrBackQ105H,
    output coreCtrlPkg::tByteEn     ByteEnQ105H,
    output logic                    ValidInstQ105H
);
    import coreCtrlPkg::*;

    // Fields that live to write-back, index = stage number
    tRegIdx    RegDstQ    [2:5];
    logic      RegWrEnQ   [2:5];
    tByteEn    ByteEnQ    [2:5];
    logic      SignExtQ   [2:5];
    tSelWrBack SelWrBackQ [2:5];
    logic      PreValidQ  [2:5];  // Sampled valid, before the enable gate
    // Fields that end at memory
    logic      IsLoadQ    [2:3];
    logic      DMemWrEnQ  [2:3];
    logic      DMemRdEnQ  [2:3];
    // Execute only
    logic      IsBranchQ102H;
    logic      IsJumpQ102H;

    always_ff @(posedge Clock) begin
        if (reset) begin
            AluOpQ102H     <= ADD;
            SelAluPcQ102H  <= 1'b0;
            SelAluImmQ102H <= 1'b0;
            LuiQ102H       <= 1'b0;
            BranchOpQ102H  <= BEQ;
            IsBranchQ102H  <= 1'b0;
            IsJumpQ102H    <= 1'b0;
            for (int s = 2; s <= 5; s++) begin
                RegDstQ[s]    <= '0;
                RegWrEnQ[s]   <= 1'b0;
                ByteEnQ[s]    <= '0;
                SignExtQ[s]   <= 1'b0;
                SelWrBackQ[s] <= WB_ALU;
                PreValidQ[s]  <= 1'b0;
            end
            for (int s = 2; s <= 3; s++) begin
                IsLoadQ[s]   <= 1'b0;
                DMemWrEnQ[s] <= 1'b0;
                DMemRdEnQ[s] <= 1'b0;
            end
        end else if (hazard.StageEn) begin
            //--------------------------------------------------
            // Q101 -> Q102
            //--------------------------------------------------
            AluOpQ102H     <= dec.AluOp;
            SelAluPcQ102H  <= dec.SelAluPc;
            SelAluImmQ102H <= dec.SelAluImm;
            LuiQ102H       <= dec.Lui;
            BranchOpQ102H  <= dec.BranchOp;
            IsBranchQ102H  <= dec.IsBranch;
            IsJumpQ102H    <= dec.IsJump;
            RegDstQ[2]     <= dec.RegDst;
            RegWrEnQ[2]    <= dec.RegWrEn;
            ByteEnQ[2]     <= dec.DMemByteEn;
            SignExtQ[2]    <= dec.SignExt;
            SelWrBackQ[2]  <= dec.SelWrBack;
            PreValidQ[2]   <= hazard.ValidInstQ101H;
            IsLoadQ[2]     <= dec.IsLoad;
            DMemWrEnQ[2]   <= dec.DMemWrEn;
            DMemRdEnQ[2]   <= dec.DMemRdEn;
            // Q102 -> Q105 shift
            // Enable is high here, so the raw valid equals the gated one
            for (int s = 3; s <= 5; s++) begin
                RegDstQ[s]    <= RegDstQ[s-1];
                RegWrEnQ[s]   <= RegWrEnQ[s-1];
                ByteEnQ[s]    <= ByteEnQ[s-1];
                SignExtQ[s]   <= SignExtQ[s-1];
                SelWrBackQ[s] <= SelWrBackQ[s-1];
                PreValidQ[s]  <= PreValidQ[s-1];
            end
            IsLoadQ[3]   <= IsLoadQ[2];
            DMemWrEnQ[3] <= DMemWrEnQ[2];
            DMemRdEnQ[3] <= DMemRdEnQ[2];
        end
    end

    //--------------------------------------------------
    // Status back to hazard control
    //--------------------------------------------------
    assign hazard.LoadPendingQ102H = PreValidQ[2] && IsLoadQ[2];
    assign hazard.LoadPendingQ103H = PreValidQ[3] && IsLoadQ[3];
    assign hazard.LoadDstQ102H     = RegDstQ[2];
    assign hazard.LoadDstQ103H     = RegDstQ[3];
    assign hazard.BranchQ102H      = PreValidQ[2] && IsBranchQ102H;  // Bubbles never redirect
    assign hazard.JumpQ102H        = PreValidQ[2] && IsJumpQ102H;

    // Memory stage
    assign DMemWrEnQ103H   = DMemWrEnQ[3];
    assign DMemRdEnQ103H   = DMemRdEnQ[3];
    assign DMemByteEnQ103H = ByteEnQ[3];

    // Write-back, low while frozen
    assign ValidInstQ105H = hazard.StageEn && PreValidQ[5];
    assign RegWrEnQ105H   = ValidInstQ105H && RegWrEnQ[5];
    assign RegDstQ105H    = RegDstQ[5];
    assign SignExtQ105H   = SignExtQ[5];
    assign SelWrBackQ105H = SelWrBackQ[5];
    assign ByteEnQ105H    = ByteEnQ[5];

endmodule

//--- logic/immGen.sv
// Immediate generator for the Q101 instruction
// Picks I/S/B/U/J from the opcode and sign-extends to 32 bits
module immGen (
    input  coreCtrlPkg::tWord InstructionQ101H,
    output coreCtrlPkg::tWord ImmediateQ101H
);
    import coreCtrlPkg::*;

    tOpcode  Opcode;
    tImmType ImmType;

    assign Opcode = tOpcode'(InstructionQ101H[6:0]);

    // Format select
    always_comb begin
        case (Opcode)
            JALR, I_OP, LOAD: ImmType = I_TYPE;
            LUI, AUIPC:       ImmType = U_TYPE;
            JAL:              ImmType = J_TYPE;
            BRANCH:           ImmType = B_TYPE;
            STORE:            ImmType = S_TYPE;
            default:          ImmType = I_TYPE;
        endcase
    end

    // Bit layout per format, sign always from bit 31
    always_comb begin
        case (ImmType)
            U_TYPE: ImmediateQ101H = {InstructionQ101H[31:12], 12'b0};
            S_TYPE: ImmediateQ101H = {{20{InstructionQ101H[31]}}, InstructionQ101H[31:25],
                                      InstructionQ101H[11:7]};
            B_TYPE: ImmediateQ101H = {{20{InstructionQ101H[31]}}, InstructionQ101H[7],
                                      InstructionQ101H[30:25], InstructionQ101H[11:8], 1'b0};
            J_TYPE: ImmediateQ101H = {{12{InstructionQ101H[31]}}, InstructionQ101H[19:12],
                                      InstructionQ101H[20], InstructionQ101H[30:21], 1'b0};
            default: ImmediateQ101H = {{20{InstructionQ101H[31]}}, InstructionQ101H[31:20]};
        endcase
    end

endmodule

//--- logic/instDecoder.sv
// RV32I base decoder for the Q101 instruction
// Produces the control bits handed to the stage registers
module instDecoder (
    input  coreCtrlPkg::tWord   InstructionQ101H,
    decodeIf.decoder            dec,
    output coreCtrlPkg::tRegIdx RegSrc1Q101H,
    output coreCtrlPkg::tRegIdx RegSrc2Q101H
);
    import coreCtrlPkg::*;

    tOpcode     Opcode;
    logic [2:0] Funct3;
    logic [6:0] Funct7;
    logic       AluEncOk;  // funct7 legal for this op
    logic       IsMemOp;

    assign Opcode  = tOpcode'(InstructionQ101H[6:0]);
    assign Funct3  = InstructionQ101H[14:12];
    assign Funct7  = InstructionQ101H[31:25];
    assign IsMemOp = (Opcode == LOAD) || (Opcode == STORE);

    //--------------------------------------------------
    // ALU operation
    //--------------------------------------------------
    always_comb begin
        dec.AluOp = ADD;  // Address and link math
        AluEncOk  = 1'b1;
        case (Opcode)
            R_OP: begin
                // Only SUB and SRA take funct7 = 0100000
                if ((Funct7 == 7'b0000000) ||
                    ((Funct7 == 7'b0100000) && ((Funct3 == 3'b000) || (Funct3 == 3'b101)))) begin
                    dec.AluOp = tAluOp'({Funct7[5], Funct3});
                end else begin
                    AluEncOk = 1'b0;  // M extension and the rest
                end
            end
            I_OP: begin
                if ((Funct3 == 3'b001) || (Funct3 == 3'b101)) begin
                    // Shifts, shamt in [24:20]
                    if ((Funct7 == 7'b0000000) ||
                        ((Funct7 == 7'b0100000) && (Funct3 == 3'b101))) begin
                        dec.AluOp = tAluOp'({Funct7[5], Funct3});
                    end else begin
                        AluEncOk = 1'b0;
                    end
                end else begin
                    dec.AluOp = tAluOp'({1'b0, Funct3});  // Imm bit 30 ignored
                end
            end
            default: begin
                dec.AluOp = ADD;
            end
        endcase
    end

    //--------------------------------------------------
    // Operand, branch and write-back control
    //--------------------------------------------------
    assign dec.SelAluPc  = (Opcode == JAL) || (Opcode == BRANCH) || (Opcode == AUIPC);
    assign dec.SelAluImm = (Opcode != R_OP);
    assign dec.Lui       = (Opcode == LUI);
    assign dec.BranchOp  = tBranchType'(Funct3);
    assign dec.IsBranch  = (Opcode == BRANCH);
    assign dec.IsJump    = (Opcode == JAL) || (Opcode == JALR);
    assign dec.IsLoad    = (Opcode == LOAD);
    assign dec.SelWrBack = dec.IsJump             ? WB_PC4  :
                           (Opcode == LOAD)       ? WB_DMEM :
                                                    WB_ALU;
    assign dec.RegDst    = InstructionQ101H[11:7];
    assign dec.RegWrEn   = AluEncOk &&
                           ((Opcode == LUI)  || (Opcode == AUIPC) || (Opcode == JAL) ||
                            (Opcode == JALR) || (Opcode == LOAD)  || (Opcode == I_OP) ||
                            (Opcode == R_OP));

    // Memory access
    assign dec.DMemWrEn   = (Opcode == STORE);
    assign dec.DMemRdEn   = (Opcode == LOAD);
    assign dec.SignExt    = (Opcode == LOAD) && !Funct3[2];  // LB/LH only
    assign dec.DMemByteEn = !IsMemOp                ? '0        :
                            (Funct3[1:0] == 2'b00)  ? BYTE_EN_B :
                            (Funct3[1:0] == 2'b01)  ? BYTE_EN_H :
                            (Funct3[1:0] == 2'b10)  ? BYTE_EN_W : '0;

    // Register file read addresses
    assign dec.UsesRegSrc2 = (Opcode == R_OP) || (Opcode == STORE) || (Opcode == BRANCH);
    assign RegSrc1Q101H    = InstructionQ101H[19:15];
    // x0 when [24:20] is immediate or shamt
    assign RegSrc2Q101H    = dec.UsesRegSrc2 ? InstructionQ101H[24:20] : '0;

endmodule

//--- logic/pipeCtrl.sv
// Pipe hazard control: load-use stall, branch/jump flush and memory freeze
// Builds the Q101 instruction (NOP when killed) and the ready signals
module pipeCtrl (
    input  logic              Clock,
    input  logic              reset,
    input  logic              DMemReady,
    input  logic              BranchCondMetQ102H,
    input  coreCtrlPkg::tWord PreInstructionQ101H,
    hazardIf.ctrl             hazard,
    output coreCtrlPkg::tWord InstructionQ101H,
    output logic              ReadyQ100H,
    output logic              ReadyQ101H,
    output logic              SelNextPcAluOutQ102H
);
    import coreCtrlPkg::*;

    tRegIdx RegSrc1;
    tRegIdx RegSrc2;
    tOpcode Opcode;
    logic   ChkRegSrc2;     // rs2 is a real operand
    logic   LoadHzrdQ102H;  // Load directly ahead
    logic   LoadHzrdQ103H;  // Load one slot ahead
    logic   LoadStall;
    logic   CoreFreeze;
    logic   flushQ103H;     // Second flush slot
    logic   InsertNop;

    assign CoreFreeze = !DMemReady;

    //--------------------------------------------------
    // Load-use detection on the raw fetched word
    //--------------------------------------------------
    assign RegSrc1    = PreInstructionQ101H[19:15];
    assign RegSrc2    = PreInstructionQ101H[24:20];
    assign Opcode     = tOpcode'(PreInstructionQ101H[6:0]);
    assign ChkRegSrc2 = (Opcode == R_OP) || (Opcode == STORE) || (Opcode == BRANCH);

    assign LoadHzrdQ102H = hazard.LoadPendingQ102H &&
                           ((RegSrc1 == hazard.LoadDstQ102H) ||
                            (ChkRegSrc2 && (RegSrc2 == hazard.LoadDstQ102H)));
    assign LoadHzrdQ103H = hazard.LoadPendingQ103H &&
                           ((RegSrc1 == hazard.LoadDstQ103H) ||
                            (ChkRegSrc2 && (RegSrc2 == hazard.LoadDstQ103H)));
    assign LoadStall     = LoadHzrdQ102H || LoadHzrdQ103H;

    //--------------------------------------------------
    // Redirect from Q102 and the two-slot flush
    //--------------------------------------------------
    assign SelNextPcAluOutQ102H = hazard.JumpQ102H ||
                                  (hazard.BranchQ102H && BranchCondMetQ102H);

    always_ff @(posedge Clock) begin
        if (reset) begin
            flushQ103H <= 1'b0;
        end else if (hazard.StageEn) begin
            flushQ103H <= SelNextPcAluOutQ102H;  // Held through a freeze
        end
    end

    // Bubble for a stall, kill for a wrong-path fetch
    assign InsertNop        = SelNextPcAluOutQ102H || flushQ103H || LoadStall;
    assign InstructionQ101H = InsertNop ? NOP_INST : PreInstructionQ101H;

    //--------------------------------------------------
    // Ready and valid
    //--------------------------------------------------
    assign hazard.StageEn = !CoreFreeze;
    // Flushed word is dropped anyway, so fetch moves on
    assign ReadyQ101H = !CoreFreeze &&
                        (!LoadStall || SelNextPcAluOutQ102H || flushQ103H);
    assign ReadyQ100H = ReadyQ101H;  // Fetch follows decode
    assign hazard.ValidInstQ101H = ReadyQ101H && !InsertNop;

endmodule

//--- logic/pipeIfs.sv
// Interfaces between the control blocks
// decodeIf carries Q101 decode, hazardIf links hazard control and the stage registers

interface decodeIf;
    import coreCtrlPkg::*;

    tRegIdx     RegDst;
    logic       RegWrEn;
    tAluOp      AluOp;
    logic       SelAluPc;
    logic       SelAluImm;
    logic       Lui;
    tBranchType BranchOp;
    logic       IsBranch;
    logic       IsJump;
    logic       IsLoad;
    logic       DMemWrEn;
    logic       DMemRdEn;
    tByteEn     DMemByteEn;
    logic       SignExt;
    tSelWrBack  SelWrBack;
    logic       UsesRegSrc2;  // R_OP, STORE, BRANCH

    modport decoder (
        output RegDst, RegWrEn, AluOp, SelAluPc, SelAluImm, Lui, BranchOp,
               IsBranch, IsJump, IsLoad, DMemWrEn, DMemRdEn, DMemByteEn,
               SignExt, SelWrBack, UsesRegSrc2
    );
    modport pipe (
        input  RegDst, RegWrEn, AluOp, SelAluPc, SelAluImm, Lui, BranchOp,
               IsBranch, IsJump, IsLoad, DMemWrEn, DMemRdEn, DMemByteEn,
               SignExt, SelWrBack, UsesRegSrc2
    );
endinterface

interface hazardIf;
    import coreCtrlPkg::*;

    logic   LoadPendingQ102H;  // Valid load in Q102
    logic   LoadPendingQ103H;
    tRegIdx LoadDstQ102H;
    tRegIdx LoadDstQ103H;
    logic   BranchQ102H;
    logic   JumpQ102H;
    logic   StageEn;           // Shared Q102..Q105 enable
    logic   ValidInstQ101H;

    modport ctrl (
        input  LoadPendingQ102H, LoadPendingQ103H, LoadDstQ102H, LoadDstQ103H,
               BranchQ102H, JumpQ102H,
        output StageEn, ValidInstQ101H
    );
    modport pipe (
        output LoadPendingQ102H, LoadPendingQ103H, LoadDstQ102H, LoadDstQ103H,
               BranchQ102H, JumpQ102H,
        input  StageEn, ValidInstQ101H
    );
endinterface

//--- run.sh
#!/bin/sh
# Build the control path testbench with Verilator, run it, scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -f all.f --top-module coreCtrlTb \
    -o coreCtrlSim || { echo "Verilator build failed"; exit 1; }
{ ./obj_dir/coreCtrlSim > sim.log 2>&1 || true; } && cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; } || exit 0

//--- sim/coreCtrlTb.sv
// Testbench for the RV32I pipe control path
// Directed tests for immediates, decode fields, load-use stall, flush and freeze
module coreCtrlTb;
    timeunit 1ns;
    timeprecision 100ps;

    import coreCtrlPkg::*;

    // Tests need about 150 cycles, 2.5x margin
    localparam int TIMEOUT_CYCLES = 400;

    logic       Clock;
    logic       reset;
    tWord       PreInstructionQ101H;
    logic       BranchCondMetQ102H;
    logic       DMemReady;
    logic       ReadyQ100H, ReadyQ101H, ReadyQ102H;
    tWord       ImmediateQ101H;
    tRegIdx     RegSrc1Q101H, RegSrc2Q101H;
    logic       SelNextPcAluOutQ102H;
    tAluOp      AluOpQ102H;
    logic       SelAluPcQ102H, SelAluImmQ102H, LuiQ102H;
    tBranchType BranchOpQ102H;
    logic       DMemWrEnQ103H, DMemRdEnQ103H;
    tByteEn     DMemByteEnQ103H;
    logic       RegWrEnQ105H;
    tRegIdx     RegDstQ105H;
    logic       SignExtQ105H;
    tSelWrBack  SelWrBackQ105H;
    tByteEn     ByteEnQ105H;
    logic       ValidInstQ105H;

    integer seed;
    int     cycleCount = 0;
    int     stallCycles;     // Cycles the last issue waited on ReadyQ101H

    coreCtrlTop coreCtrlTop_inst (.*);

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // Hang guard
    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    //--------------------------------------------------
    // Check, encoders and immediate reference
    //--------------------------------------------------
    task automatic checkValue(input string name, input tWord actual, input tWord expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic tWord encI(input logic [11:0] imm, input tRegIdx rs1,
                                  input logic [2:0] f3, input tRegIdx rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic tWord encS(input logic [11:0] imm, input tRegIdx rs2, input tRegIdx rs1,
                                  input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic tWord encR(input logic [6:0] f7, input tRegIdx rs2, input tRegIdx rs1,
                                  input logic [2:0] f3, input tRegIdx rd);
        return {f7, rs2, rs1, f3, rd, R_OP};
    endfunction

    function automatic tWord encB(input logic [12:0] imm, input tRegIdx rs2, input tRegIdx rs1,
                                  input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    // Sign-extend the low n bits
    function automatic tWord signExt(input tWord value, input int bits);
        return tWord'($signed(value << (32 - bits)) >>> (32 - bits));
    endfunction

    function automatic tWord refImm(input tWord inst, input tImmType fmt);
        tWord raw;
        case (fmt)
            S_TYPE: raw = signExt(32'({inst[31:25], inst[11:7]}), 12);
            B_TYPE: raw = signExt(32'({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}), 13);
            U_TYPE: raw = {inst[31:12], 12'h000};
            J_TYPE: raw = signExt(32'({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}), 21);
            default: raw = signExt(32'(inst[31:20]), 12);
        endcase
        return raw;
    endfunction

    //--------------------------------------------------
    // Drive helpers
    //--------------------------------------------------
    // Present a word to Q101 and hold it until decode accepts it
    task automatic issue(input tWord inst);
        @(posedge Clock);
        PreInstructionQ101H <= inst;
        stallCycles = 0;
        @(negedge Clock);
        while (!ReadyQ101H) begin
            stallCycles++;
            @(negedge Clock);
        end
    endtask

    task automatic drainPipe;
        repeat (5) issue(NOP_INST);  // Flushes every stage with bubbles
    endtask

    //--------------------------------------------------
    // Directed tests
    //--------------------------------------------------
    // Pipe frozen, so random words sit in Q101 without entering the pipe
    task automatic checkImmFormat(input logic [6:0] opc, input tImmType fmt, input int count);
        tWord inst;
        for (int i = 0; i < count; i++) begin
            inst = $random(seed);
            inst[6:0] = opc;
            @(posedge Clock);
            PreInstructionQ101H <= inst;
            @(negedge Clock);
            checkValue("ImmediateQ101H", ImmediateQ101H, refImm(inst, fmt));
        end
    endtask

    task automatic immediateFormats;
        @(posedge Clock);
        DMemReady <= 1'b0;
        checkImmFormat(I_OP, I_TYPE, 4);
        checkImmFormat(LOAD, I_TYPE, 2);
        checkImmFormat(JALR, I_TYPE, 2);
        checkImmFormat(STORE, S_TYPE, 4);
        checkImmFormat(BRANCH, B_TYPE, 4);
        checkImmFormat(LUI, U_TYPE, 3);
        checkImmFormat(AUIPC, U_TYPE, 2);
        checkImmFormat(JAL, J_TYPE, 4);
        @(posedge Clock);
        DMemReady           <= 1'b1;
        PreInstructionQ101H <= NOP_INST;
    endtask

    task automatic aluWriteBack(input tWord inst, input tAluOp expOp, input tRegIdx expRd,
                                input logic expSelImm, input logic expLui);
        issue(inst);
        issue(NOP_INST);
        checkValue("AluOpQ102H", 32'(AluOpQ102H), 32'(expOp));  // One edge in
        checkValue("SelAluImmQ102H", 32'(SelAluImmQ102H), 32'(expSelImm));
        checkValue("SelAluPcQ102H", 32'(SelAluPcQ102H), 32'd0);  // No PC operand
        checkValue("LuiQ102H", 32'(LuiQ102H), 32'(expLui));
        repeat (3) issue(NOP_INST);
        checkValue("ValidInstQ105H", 32'(ValidInstQ105H), 32'd1);
        checkValue("RegWrEnQ105H", 32'(RegWrEnQ105H), 32'd1);
        checkValue("RegDstQ105H", 32'(RegDstQ105H), 32'(expRd));
        checkValue("SelWrBackQ105H", 32'(SelWrBackQ105H), 32'(WB_ALU));
    endtask

    task automatic loadFields(input logic [2:0] funct3, input logic expSign);
        issue(encI(12'd0, 5'd1, funct3, 5'd6, LOAD));    // Byte load into x6
        repeat (2) issue(NOP_INST);
        checkValue("DMemRdEnQ103H", 32'(DMemRdEnQ103H), 32'd1);
        checkValue("DMemByteEnQ103H", 32'(DMemByteEnQ103H), 32'h1);
        repeat (2) issue(NOP_INST);
        checkValue("SignExtQ105H", 32'(SignExtQ105H), 32'(expSign));
        checkValue("SelWrBackQ105H", 32'(SelWrBackQ105H), 32'(WB_DMEM));
        checkValue("RegDstQ105H", 32'(RegDstQ105H), 32'd6);
        checkValue("ByteEnQ105H", 32'(ByteEnQ105H), 32'h1);
        drainPipe;
    endtask

    task automatic memoryFields;
        issue(encS(12'd8, 5'd2, 5'd1, 3'b001));          // SH x2, 8(x1)
        checkValue("RegSrc1Q101H", 32'(RegSrc1Q101H), 32'd1);
        checkValue("RegSrc2Q101H", 32'(RegSrc2Q101H), 32'd2);
        repeat (2) issue(NOP_INST);
        checkValue("DMemWrEnQ103H", 32'(DMemWrEnQ103H), 32'd1);
        checkValue("DMemByteEnQ103H", 32'(DMemByteEnQ103H), 32'h3);
        checkValue("DMemRdEnQ103H", 32'(DMemRdEnQ103H), 32'd0);
        drainPipe;
        loadFields(3'b000, 1'b1);  // LB
        loadFields(3'b100, 1'b0);  // LBU
    endtask

    task automatic loadUseStall;
        // Load directly ahead
        issue(encI(12'd0, 5'd1, 3'b010, 5'd3, LOAD));
        issue(encR(7'h00, 5'd1, 5'd3, 3'b000, 5'd4));
        checkValue("stall cycles, load directly ahead", 32'(stallCycles), 32'd2);
        drainPipe;
        // One independent instruction in between
        issue(encI(12'd0, 5'd1, 3'b010, 5'd3, LOAD));
        issue(encI(12'd1, 5'd0, 3'b000, 5'd9, I_OP));
        issue(encR(7'h00, 5'd1, 5'd3, 3'b000, 5'd4));
        checkValue("stall cycles, one gap", 32'(stallCycles), 32'd1);
        drainPipe;
        // ADDI with 3 in the rs2 bit field is no match, its rs1 is
        issue(encI(12'd0, 5'd1, 3'b010, 5'd3, LOAD));
        issue(encI(12'd3, 5'd1, 3'b000, 5'd5, I_OP));
        checkValue("stall cycles, ADDI rs2 bits", 32'(stallCycles), 32'd0);
        issue(encI(12'd0, 5'd3, 3'b000, 5'd6, I_OP));
        checkValue("stall cycles, ADDI rs1", 32'(stallCycles), 32'd1);
        drainPipe;
    endtask

    task automatic branchFlush(input logic condMet, input tBranchType brType);
        issue(encB(13'd16, 5'd2, 5'd1, brType));         // Branch x1, x2, +16
        @(posedge Clock);
        PreInstructionQ101H <= encI(12'd1, 5'd0, 3'b000, 5'd10, I_OP);
        BranchCondMetQ102H  <= condMet;                    // Branch now in Q102
        @(negedge Clock);
        checkValue("SelNextPcAluOutQ102H", 32'(SelNextPcAluOutQ102H), 32'(condMet));
        checkValue("ReadyQ101H", 32'(ReadyQ101H), 32'd1);
        checkValue("BranchOpQ102H", 32'(BranchOpQ102H), 32'(brType));
        checkValue("SelAluPcQ102H", 32'(SelAluPcQ102H), 32'd1);  // Target is PC plus offset
        @(posedge Clock);
        PreInstructionQ101H <= encI(12'd1, 5'd0, 3'b000, 5'd11, I_OP);
        BranchCondMetQ102H  <= 1'b0;
        @(negedge Clock);
        repeat (3) issue(NOP_INST);
        checkValue("ValidInstQ105H, first after branch", 32'(ValidInstQ105H), 32'(!condMet));
        issue(NOP_INST);
        checkValue("ValidInstQ105H, second after branch", 32'(ValidInstQ105H), 32'(!condMet));
        drainPipe;
    endtask

    task automatic freezeHold;
        for (int rd = 12; rd <= 14; rd++) begin
            issue(encI(12'd1, 5'd0, 3'b000, 5'(rd), I_OP));
        end
        issue(NOP_INST);
        @(posedge Clock);
        DMemReady <= 1'b0;  // x12 lands in Q105 on this edge
        repeat (5) begin
            @(negedge Clock);
            checkValue("ReadyQ100H", 32'(ReadyQ100H), 32'd0);
            checkValue("ReadyQ101H", 32'(ReadyQ101H), 32'd0);
            checkValue("ReadyQ102H", 32'(ReadyQ102H), 32'd0);
            checkValue("ValidInstQ105H", 32'(ValidInstQ105H), 32'd0);
            checkValue("RegDstQ105H", 32'(RegDstQ105H), 32'd12);
        end
        @(posedge Clock);
        DMemReady <= 1'b1;
        for (int rd = 12; rd <= 14; rd++) begin
            @(negedge Clock);
            checkValue("ValidInstQ105H", 32'(ValidInstQ105H), 32'd1);
            checkValue("RegDstQ105H", 32'(RegDstQ105H), 32'(rd));
        end
    endtask

    //--------------------------------------------------
    // Sequence
    //--------------------------------------------------
    initial begin
        seed                = 32'h405f_2112;
        reset               = 1'b1;
        DMemReady           = 1'b1;
        BranchCondMetQ102H  = 1'b0;
        PreInstructionQ101H = NOP_INST;
        repeat (10) @(posedge Clock);
        reset <= 1'b0;
        @(negedge Clock);
        checkValue("ValidInstQ105H after reset", 32'(ValidInstQ105H), 32'd0);
        checkValue("RegWrEnQ105H after reset", 32'(RegWrEnQ105H), 32'd0);
        checkValue("DMemWrEnQ103H after reset", 32'(DMemWrEnQ103H), 32'd0);
        checkValue("DMemRdEnQ103H after reset", 32'(DMemRdEnQ103H), 32'd0);
        checkValue("SelNextPcAluOutQ102H after reset", 32'(SelNextPcAluOutQ102H), 32'd0);

        immediateFormats;
        aluWriteBack(encI(12'h123, 5'd0, 3'b000, 5'd5, I_OP), ADD, 5'd5, 1'b1, 1'b0);  // ADDI x5
        aluWriteBack(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd7), SUB, 5'd7, 1'b0, 1'b0);     // SUB x7
        aluWriteBack({20'h12345, 5'd8, LUI}, ADD, 5'd8, 1'b1, 1'b1);                   // LUI x8
        memoryFields;
        loadUseStall;
        branchFlush(1'b1, BEQ);
        branchFlush(1'b0, BEQ);
        branchFlush(1'b1, BGEU);
        freezeHold;

        $display("Test OK");
        $finish;
    end

endmodule
